//--- Makefile
# Verilator flow for the multiply/divide unit

VERILATOR    ?= verilator
FILELIST     := src.f
TB_TOP       := tb_md_unit
RTL_TOP      := md_unit
BUILD_DIR    := obj_dir
LOG          := sim.log
PASS_MSG     := *** PASSED ***
COMMON_FLAGS := --timing --assert
LINT_FLAGS   := --lint-only
SIM_FLAGS    := --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/md_ref.svh
/*
 * Reference model of the multiply/divide unit
 * Expected result of one operation from the architectural rules
 */

`ifndef MD_REF_SVH
`define MD_REF_SVH

function automatic logic [`MD_XLEN-1:0] md_ref(input md_op_e              op,
                                                input logic [1:0]          mode,
                                                input logic [`MD_XLEN-1:0] a,
                                                input logic [`MD_XLEN-1:0] b);
  logic [2*`MD_XLEN-1:0] wide_a;
  logic [2*`MD_XLEN-1:0] wide_b;
  logic [2*`MD_XLEN-1:0] prod;
  logic                  neg_a;
  logic                  neg_b;
  logic                  ovf;
  logic [`MD_XLEN-1:0]   mag_a;
  logic [`MD_XLEN-1:0]   mag_b;
  logic [`MD_XLEN-1:0]   quo;
  logic [`MD_XLEN-1:0]   rem;
  logic [`MD_XLEN-1:0]   res;

  // Each operand widened by its own signedness bit
  wide_a = mode[0] ? {{`MD_XLEN{a[`MD_XLEN-1]}}, a} : {{`MD_XLEN{1'b0}}, a};
  wide_b = mode[1] ? {{`MD_XLEN{b[`MD_XLEN-1]}}, b} : {{`MD_XLEN{1'b0}}, b};
  prod   = wide_a * wide_b;

  neg_a = mode[0] & a[`MD_XLEN-1];
  neg_b = mode[1] & b[`MD_XLEN-1];
  mag_a = neg_a ? -a : a;
  mag_b = neg_b ? -b : b;
  quo   = (mag_b == '0) ? '0 : mag_a / mag_b;
  rem   = (mag_b == '0) ? '0 : mag_a % mag_b;
  // Most negative dividend over minus one
  ovf   = neg_a && mode[1] && (a == {1'b1, {(`MD_XLEN-1){1'b0}}}) && (b == '1);

  case (op)
    MD_OP_MUL:  res = prod[`MD_XLEN-1:0];
    MD_OP_MULH: res = prod[2*`MD_XLEN-1:`MD_XLEN];
    MD_OP_DIV:  res = (b == '0) ? '1 : ovf ? a : (neg_a ^ neg_b) ? -quo : quo;
    default:    res = (b == '0) ? a : ovf ? '0 : neg_a ? -rem : rem;
  endcase
  return res;
endfunction

`endif

//--- dv/tb_md_unit.sv
/*
 * Testbench for the multiply/divide unit
 * Random and corner operands checked against a reference model
 */

`timescale 1ns/100ps
`include "md_defs.svh"

module tb_md_unit;
  import md_pkg::*;

  `include "md_ref.svh"

  localparam int RESET_CYCLES = 5;
  localparam int NUM_TESTS    = 86;
  // Longest divide plus issue and settling overhead
  localparam int TEST_CYCLES  = `MD_DIV_STEPS + 13;
  localparam int MAX_CYCLES   = NUM_TESTS * TEST_CYCLES + RESET_CYCLES;

  logic                clk_i;
  logic                rst_ni;
  logic                start_i;
  md_op_e              operator_i;
  logic [1:0]          signed_mode_i;
  logic [`MD_XLEN-1:0] op_a_i;
  logic [`MD_XLEN-1:0] op_b_i;
  logic [`MD_XLEN-1:0] result_o;
  logic                valid_o;
  logic                busy_o;

  integer              seed;
  int                  cycle;
  int                  test_num;
  int                  err_count;
  int                  valid_count;
  int                  pass_count;
  int                  fail_count;
  int                  last_lat;
  int                  nonzero_lat;
  logic [`MD_XLEN-1:0] exp_result;
  logic [`MD_XLEN-1:0] a;
  logic [`MD_XLEN-1:0] b;
  logic [1:0]          mulh_modes [3] = '{2'b00, 2'b01, 2'b11};
  logic [`MD_XLEN-1:0] corner [4] = '{32'h0, 32'h1, 32'h8000_0000, 32'hffff_ffff};

  md_unit DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (result_o),
    .valid_o       (valid_o),
    .busy_o        (busy_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Result compare at every valid pulse, half a cycle after the edge
  always @(negedge clk_i) begin
    if (rst_ni && valid_o) begin
      valid_count = valid_count + 1;
      if (result_o !== exp_result) begin
        $display("Fail result_o: expected %h got %h", exp_result, result_o);
        err_count = err_count + 1;
      end
    end
  end

  // One operation; inject pulses a second start while the first is busy
  task automatic run_op(input md_op_e op, input logic [1:0] mode,
                        input logic [`MD_XLEN-1:0] op_a, input logic [`MD_XLEN-1:0] op_b,
                        input int exp_lat, input bit inject);
    int lat;
    int errs;
    int valids;
    bit got;
    lat    = 0;
    got    = 0;
    errs   = err_count;
    valids = valid_count;
    @(posedge clk_i);
    exp_result    = md_ref(op, mode, op_a, op_b);
    start_i       <= 1'b1;
    operator_i    <= op;
    signed_mode_i <= mode;
    op_a_i        <= op_a;
    op_b_i        <= op_b;
    while (!got && lat <= TEST_CYCLES) begin
      @(negedge clk_i);
      if (valid_o) begin
        got = 1;
      end else begin
        lat++;
        if (inject && lat == 2 && !busy_o) begin
          $display("busy_o was low when the second start was driven");
          err_count++;
        end
        @(posedge clk_i);
        start_i <= inject && lat == 2;
        if (inject) begin
          op_a_i <= ~op_a;
        end
      end
    end
    if (!got) begin
      $display("valid_o never arrived for %s", op.name());
      err_count++;
    end else if (exp_lat > 0 && lat != exp_lat) begin
      $display("valid_o came after %0d cycles instead of %0d", lat, exp_lat);
      err_count++;
    end else if (exp_lat == 0 && lat > 40) begin
      $display("valid_o came after %0d cycles, later than the 40 cycle limit", lat);
      err_count++;
    end
    // Let any stray second result show up
    repeat (inject ? TEST_CYCLES : 1) @(posedge clk_i);
    if (got && valid_count - valids != 1) begin
      $display("Expected one valid_o pulse but saw %0d", valid_count - valids);
      err_count++;
    end
    test_num++;
    last_lat = lat;
    if (err_count == errs) begin
      pass_count++;
      $display("Test %0d %s mode %b a=%h b=%h ok in %0d cycles",
               test_num, op.name(), mode, op_a, op_b, lat);
    end else begin
      fail_count++;
      $display("Test %0d %s mode %b a=%h b=%h error", test_num, op.name(), mode, op_a, op_b);
    end
  endtask

  initial begin
    seed          = 58;
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    start_i       = 1'b0;
    operator_i    = MD_OP_MUL;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    exp_result    = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < 6; i++) begin
      run_op(MD_OP_MUL, 2'($random(seed)), $random(seed), $random(seed), 5, 0);
    end

    // MULH in modes 00, 01 and 11, random then every corner pair
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < 3; i++) begin
        run_op(MD_OP_MULH, mulh_modes[m], $random(seed), $random(seed), 6, 0);
      end
      for (int i = 0; i < 16; i++) begin
        run_op(MD_OP_MULH, mulh_modes[m], corner[i/4], corner[i%4], 6, 0);
      end
    end

    // Bits 2 and 3 force a negative dividend and divisor
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      b = $random(seed);
      a[`MD_XLEN-1] = a[`MD_XLEN-1] | i[2];
      b[`MD_XLEN-1] = b[`MD_XLEN-1] | i[3];
      run_op(i[0] ? MD_OP_REM : MD_OP_DIV, i[1] ? 2'b11 : 2'b00, a, b, 0, 0);
    end

    // Zero divisor must beat a normal divide of the same dividend
    for (int i = 0; i < 2; i++) begin
      a = $random(seed);
      b = $random(seed) | 1;
      run_op(i[0] ? MD_OP_REM : MD_OP_DIV, 2'b11, a, b, 0, 0);
      nonzero_lat = last_lat;
      run_op(i[0] ? MD_OP_REM : MD_OP_DIV, 2'b11, a, '0, 0, 0);
      if (last_lat >= nonzero_lat) begin
        $display("Division by zero took %0d cycles, no faster than %0d", last_lat, nonzero_lat);
        err_count++;
      end
    end

    run_op(MD_OP_DIV, 2'b11, corner[2], '1, 0, 0);
    run_op(MD_OP_REM, 2'b11, corner[2], '1, 0, 0);
    run_op(MD_OP_MUL, 2'b00, $random(seed), $random(seed), 5, 1);

    $display("Tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- rtl/md_defs.svh
/*
 * Multiply/divide unit widths and step counts
 */

`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Datapath word width
`define MD_XLEN 32

// One operand half for the 17x17 MAC
`define MD_HALF 16

// Accumulator and MAC result width
`define MD_MAC_W 34

// Quotient bits produced by the long divider
`define MD_DIV_STEPS 32

`endif

//--- rtl/md_div_long.sv
/*
 * Restoring long divider for DIV and REM, signed or unsigned
 * Zero divisor takes a short path to the architectural result
 */

`timescale 1ns/100ps
`include "md_defs.svh"

module md_div_long (
  input  logic                clk_i,
  input  logic                rst_ni,
  md_req_if.engine            req,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);
  import md_pkg::*;

  div_state_e          state_q;
  div_state_e          state_d;
  logic [4:0]          cnt_q;
  logic                div_op;
  logic                is_div;
  logic                b_zero;
  logic                sign_a;
  logic                sign_b;
  logic                negate;
  logic [`MD_XLEN:0]   sub_a;
  logic [`MD_XLEN:0]   sub_b;
  logic [`MD_XLEN+1:0] sub_res;
  logic                geq;
  logic [`MD_XLEN-1:0] rem_next;
  logic [`MD_XLEN-1:0] quo_next;
  logic [`MD_XLEN-1:0] num_q;
  logic [`MD_XLEN-1:0] den_q;
  logic [`MD_XLEN-1:0] rem_q;
  logic [`MD_XLEN-1:0] quo_q;
  logic [`MD_XLEN-1:0] res_q;

  assign div_op = (req.op == MD_OP_DIV) || (req.op == MD_OP_REM);
  assign is_div = (req.op == MD_OP_DIV);
  assign b_zero = (req.op_b == '0);
  assign sign_a = req.a_signed & req.op_a[`MD_XLEN-1];
  assign sign_b = req.b_signed & req.op_b[`MD_XLEN-1];
  // Quotient negative on differing signs, remainder follows the dividend
  assign negate = is_div ? (sign_a ^ sign_b) : sign_a;

  // Shared subtractor with a borrow bit on top
  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};

  always_comb begin
    sub_a = {rem_q, num_q[cnt_q]};
    sub_b = {1'b0, den_q};
    case (state_q)
      DIV_ABS_A: begin
        sub_a = '0;
        sub_b = {1'b0, req.op_a};
      end
      DIV_ABS_B: begin
        sub_a = '0;
        sub_b = {1'b0, req.op_b};
      end
      DIV_SIGN: begin
        sub_a = '0;
        sub_b = {1'b0, res_q};
      end
      default: ;
    endcase
  end

  // One restoring step, the quotient bit shifts in from the right
  assign geq      = ~sub_res[`MD_XLEN+1];
  assign rem_next = geq ? sub_res[`MD_XLEN-1:0] : sub_a[`MD_XLEN-1:0];
  assign quo_next = {quo_q[`MD_XLEN-2:0], geq};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DIV_IDLE: begin
        if (req.go && div_op) begin
          state_d = b_zero ? DIV_FINISH : DIV_ABS_A;
        end
      end
      DIV_ABS_A:  state_d = DIV_ABS_B;
      DIV_ABS_B:  state_d = DIV_COMP;
      DIV_COMP: begin
        if (cnt_q == 5'd1) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST:   state_d = DIV_SIGN;
      DIV_SIGN:   state_d = DIV_FINISH;
      DIV_FINISH: state_d = DIV_IDLE;
      default:    state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == DIV_ABS_B) begin
        cnt_q <= 5'(`MD_DIV_STEPS - 1);
      end else if (state_q == DIV_COMP) begin
        cnt_q <= cnt_q - 5'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      DIV_IDLE: begin
        // Zero-divisor result, overwritten later on the long path
        if (req.go) begin
          res_q <= is_div ? '1 : req.op_a;
        end
      end
      DIV_ABS_A: begin
        num_q <= sign_a ? sub_res[`MD_XLEN-1:0] : req.op_a;
      end
      DIV_ABS_B: begin
        den_q <= sign_b ? sub_res[`MD_XLEN-1:0] : req.op_b;
        rem_q <= '0;
        quo_q <= '0;
      end
      DIV_COMP: begin
        rem_q <= rem_next;
        quo_q <= quo_next;
      end
      DIV_LAST: begin
        res_q <= is_div ? quo_next : rem_next;
      end
      DIV_SIGN: begin
        if (negate) begin
          res_q <= sub_res[`MD_XLEN-1:0];
        end
      end
      default: ;
    endcase
  end

  assign done_o   = (state_q == DIV_FINISH);
  assign result_o = res_q;

  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH});

endmodule

//--- rtl/md_issue.sv
/*
 * Issue block of the multiply/divide unit
 * Accepts start strobes, holds the request and busy flag,
 * and registers the finished engine's result with a valid pulse
 */

`timescale 1ns/100ps
`include "md_defs.svh"

module md_issue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_pkg::md_op_e      operator_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  md_req_if.issuer            req,
  input  logic                mult_done_i,
  input  logic [`MD_XLEN-1:0] mult_result_i,
  input  logic                div_done_i,
  input  logic [`MD_XLEN-1:0] div_result_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o,
  output logic                busy_o
);

  logic accept;
  logic any_done;
  logic busy_q;
  logic fin_q;
  logic valid_q;

  // Starts while an operation is in flight are dropped
  assign accept   = start_i & ~busy_q;
  assign any_done = mult_done_i | div_done_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req.go   <= 1'b0;
      busy_q   <= 1'b0;
      fin_q    <= 1'b0;
      valid_q  <= 1'b0;
      result_o <= '0;
    end else begin
      req.go <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (fin_q) begin
        busy_q <= 1'b0;
      end
      // Result is captured first, valid follows one cycle later
      fin_q   <= any_done;
      valid_q <= fin_q;
      if (any_done) begin
        result_o <= mult_done_i ? mult_result_i : div_result_i;
      end
    end
  end

  // Request payload, held until the next accepted start
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req.op       <= operator_i;
      req.a_signed <= signed_mode_i[0];
      req.b_signed <= signed_mode_i[1];
      req.op_a     <= op_a_i;
      req.op_b     <= op_b_i;
    end
  end

  assign valid_o = valid_q;
  assign busy_o  = busy_q;

  // Engines only finish while a request is open, and never both at once
  a_single_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_done |-> (busy_q && !(mult_done_i && div_done_i)));

endmodule

//--- rtl/md_mult_mac.sv
/*
 * Sequential multiplier built around one 17x17 signed MAC
 * MUL finishes in three steps, MULH in four
 */

`timescale 1ns/100ps
`include "md_defs.svh"

module md_mult_mac (
  input  logic                clk_i,
  input  logic                rst_ni,
  md_req_if.engine            req,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);
  import md_pkg::*;

  mult_state_e                state_q;
  mult_state_e                state_d;
  logic                       mul_op;
  logic                       is_mul;
  logic                       a_neg;
  logic                       b_neg;
  logic [`MD_HALF-1:0]        mac_a;
  logic [`MD_HALF-1:0]        mac_b;
  logic                       sign_a;
  logic                       sign_b;
  logic signed [`MD_MAC_W-1:0] accum;
  logic signed [`MD_MAC_W-1:0] mac_res;
  logic [`MD_MAC_W-1:0]       acc_d;
  logic [`MD_MAC_W-1:0]       acc_q;

  assign mul_op      = (req.op == MD_OP_MUL) || (req.op == MD_OP_MULH);
  assign is_mul      = (req.op == MD_OP_MUL);
  assign a_neg       = req.a_signed & req.op_a[`MD_XLEN-1];
  assign b_neg       = req.b_signed & req.op_b[`MD_XLEN-1];

  // Sign bit is only set on a signed upper half
  assign mac_res = $signed({sign_a, mac_a}) * $signed({sign_b, mac_b}) + accum;

  always_comb begin
    mac_a    = req.op_a[`MD_HALF-1:0];
    mac_b    = req.op_b[`MD_HALF-1:0];
    sign_a   = 1'b0;
    sign_b   = 1'b0;
    accum    = '0;
    acc_d    = mac_res;
    state_d  = state_q;
    done_o   = 1'b0;
    result_o = mac_res[`MD_XLEN-1:0];

    unique case (state_q)
      ALBL: begin
        if (req.go && mul_op) begin
          state_d = ALBH;
        end
      end
      ALBH: begin
        mac_b  = req.op_b[`MD_XLEN-1:`MD_HALF];
        sign_b = b_neg;
        // al*bl is unsigned, so its upper half carries in without sign
        accum  = {{(`MD_MAC_W-`MD_HALF){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
        if (is_mul) begin
          acc_d = {{(`MD_MAC_W-`MD_XLEN){1'b0}}, mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
        end
        state_d = AHBL;
      end
      AHBL: begin
        mac_a  = req.op_a[`MD_XLEN-1:`MD_HALF];
        sign_a = a_neg;
        if (is_mul) begin
          // Only bits 31:16 of the running sum remain to be formed
          accum    = {{(`MD_MAC_W-`MD_HALF){1'b0}}, acc_q[`MD_XLEN-1:`MD_HALF]};
          result_o = {mac_res[`MD_HALF-1:0], acc_q[`MD_HALF-1:0]};
          done_o   = 1'b1;
          state_d  = ALBL;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end
      AHBH: begin
        mac_a  = req.op_a[`MD_XLEN-1:`MD_HALF];
        mac_b  = req.op_b[`MD_XLEN-1:`MD_HALF];
        sign_a = a_neg;
        sign_b = b_neg;
        // Cross terms shifted down by a half and sign-extended
        accum  = {{(`MD_MAC_W-`MD_HALF-2){acc_q[`MD_MAC_W-1]}},
                  acc_q[`MD_MAC_W-1:`MD_HALF]};
        done_o  = 1'b1;
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else begin
      state_q <= state_d;
    end
  end

  // Accumulator
  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  a_state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_q));

endmodule

//--- rtl/md_pkg.sv
/*
 * Multiply/divide unit types
 * Operator encoding and the engine state machines
 */

package md_pkg;

  // Operator selected by the issuing stage
  typedef enum logic [1:0] {
    MD_OP_MUL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Partial product step of the MAC multiplier
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  // Long division sequence
  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

endpackage

//--- rtl/md_req_if.sv
/*
 * Registered request from the issue block to both engines
 */

`timescale 1ns/100ps
`include "md_defs.svh"

interface md_req_if;
  import md_pkg::*;

  // Start strobe, one cycle wide
  logic                go;
  // Operator and operand signedness, stable until the next go
  md_op_e              op;
  logic                a_signed;
  logic                b_signed;
  logic [`MD_XLEN-1:0] op_a;
  logic [`MD_XLEN-1:0] op_b;

  modport issuer (
    output go, op, a_signed, b_signed, op_a, op_b
  );

  modport engine (
    input go, op, a_signed, b_signed, op_a, op_b
  );

endinterface

//--- rtl/md_unit.sv
/*
 * Multiply/divide unit top level
 * Issue block feeding a MAC multiplier and a long divider
 */

`timescale 1ns/100ps
`include "md_defs.svh"

module md_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_pkg::md_op_e      operator_i,
  input  logic [1:0]          signed_mode_i,
  input  logic [`MD_XLEN-1:0] op_a_i,
  input  logic [`MD_XLEN-1:0] op_b_i,
  output logic [`MD_XLEN-1:0] result_o,
  output logic                valid_o,
  output logic                busy_o
);

  logic                mult_done;
  logic [`MD_XLEN-1:0] mult_result;
  logic                div_done;
  logic [`MD_XLEN-1:0] div_result;

  md_req_if req_if ();

  md_issue u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .req           (req_if.issuer),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .div_done_i    (div_done),
    .div_result_i  (div_result),
    .result_o      (result_o),
    .valid_o       (valid_o),
    .busy_o        (busy_o)
  );

  // Both engines see every request and pick out their own operators
  md_mult_mac u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (req_if.engine),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  md_div_long u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req      (req_if.engine),
    .done_o   (div_done),
    .result_o (div_result)
  );

endmodule

//--- src.f
+incdir+rtl
+incdir+dv
rtl/md_pkg.sv
rtl/md_req_if.sv
rtl/md_issue.sv
rtl/md_mult_mac.sv
rtl/md_div_long.sv
rtl/md_unit.sv
dv/tb_md_unit.sv
